/* include/exu_params.svh */
`ifndef EXU_PARAMS_SVH
`define EXU_PARAMS_SVH

// integer data path width, rv64
`define EXU_XLEN 64

// register index width, x0..x31
`define EXU_REG_W 5

// shift-add iterations in the multiplier
// one multiplier bit retired per cycle
`define EXU_MUL_CYCLES 64

// byte distance to the next sequential instruction
// also the link offset for jal and jalr
`define EXU_INST_STEP 4

`endif

/* hdl/exu_pkg.sv */
`include "exu_params.svh"

package exu_pkg;

    // instruction class as seen by the execute stage
    typedef enum logic [3:0] {
        op_lui,
        op_auipc,
        op_jal,
        op_jalr,
        op_branch,
        op_load,
        op_store,
        op_alu_imm,
        op_alu_reg,
        op_mul
    } op_class_e;

    // alu function select
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_slt,
        alu_sltu,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra
    } alu_op_e;

    // decode to execute payload
    typedef struct packed {
        logic [`EXU_XLEN-1:0]  pc;
        op_class_e             op_class;
        logic [2:0]            funct3;
        // funct7 bit 5, sub or arithmetic shift
        logic                  alt;
        logic [`EXU_REG_W-1:0] rd;
        logic [`EXU_REG_W-1:0] rs1;
        logic [`EXU_REG_W-1:0] rs2;
        logic [`EXU_XLEN-1:0]  src_a;
        logic [`EXU_XLEN-1:0]  src_b;
        logic [`EXU_XLEN-1:0]  imm;
    } id_ex_t;

    // one forwarding source, memory or write-back
    typedef struct packed {
        logic                  wen;
        logic [`EXU_REG_W-1:0] rd;
        logic [`EXU_XLEN-1:0]  data;
    } bypass_t;

    // execute to memory payload
    typedef struct packed {
        logic [`EXU_XLEN-1:0]  pc;
        op_class_e             op_class;
        logic [2:0]            funct3;
        logic [`EXU_REG_W-1:0] rd;
        logic [`EXU_XLEN-1:0]  result;
        logic [`EXU_XLEN-1:0]  store_data;
    } ex_mem_t;

    // pc redirect toward fetch
    typedef struct packed {
        logic                 taken;
        logic [`EXU_XLEN-1:0] target;
    } redirect_t;

endpackage

/* hdl/exu_stage_reg.sv */
`timescale 1ns/1ps

module exu_stage_reg (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             load,
    input  logic             flush,
    input  logic             valid_in,
    input  exu_pkg::id_ex_t  id_in,
    output logic             valid,
    output exu_pkg::id_ex_t  id
);

    // valid bit, flush beats load
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid <= 1'b0;
        end else if (flush) begin
            valid <= 1'b0;
        end else if (load) begin
            valid <= valid_in;
        end
    end

    // payload only meaningful while valid is high
    always_ff @(posedge clk) begin
        if (load) begin
            id <= id_in;
        end
    end

    // a flushed slot never shows up as valid
    property p_flush_kills;
        @(posedge clk) disable iff (!arst_n)
        flush |=> !valid;
    endproperty

    a_flush_kills : assert property (p_flush_kills)
        else $error("stage register still valid after flush");

endmodule

/* hdl/exu_forward.sv */
`timescale 1ns/1ps
`include "exu_params.svh"

module exu_forward (
    input  logic [`EXU_REG_W-1:0] rs1,
    input  logic [`EXU_REG_W-1:0] rs2,
    input  logic [`EXU_XLEN-1:0]  src_a,
    input  logic [`EXU_XLEN-1:0]  src_b,
    input  logic                  uses_rs2,
    input  exu_pkg::bypass_t      mem_bypass,
    input  exu_pkg::bypass_t      wb_bypass,
    output logic [`EXU_XLEN-1:0]  op_a,
    output logic [`EXU_XLEN-1:0]  op_b
);

    // pick the freshest copy of one source register
    // memory stage is younger than write-back, so it wins
    function automatic logic [`EXU_XLEN-1:0] pick (
        input logic [`EXU_REG_W-1:0] rs,
        input logic [`EXU_XLEN-1:0]  reg_val,
        input logic                  en,
        input exu_pkg::bypass_t      mem_src,
        input exu_pkg::bypass_t      wb_src
    );
        logic hit_ok;
        hit_ok = en && (rs != '0);
        if (hit_ok && mem_src.wen && (mem_src.rd == rs)) begin
            return mem_src.data;
        end else if (hit_ok && wb_src.wen && (wb_src.rd == rs)) begin
            return wb_src.data;
        end
        return reg_val;
    endfunction

    // rs1 is always read
    assign op_a = pick(rs1, src_a, 1'b1, mem_bypass, wb_bypass);
    // rs2 field holds imm bits for i-type, so gate it
    assign op_b = pick(rs2, src_b, uses_rs2, mem_bypass, wb_bypass);

endmodule

/* hdl/exu_alu_ctrl.sv */
`timescale 1ns/1ps
`include "exu_params.svh"

module exu_alu_ctrl (
    input  exu_pkg::id_ex_t      id,
    input  logic [`EXU_XLEN-1:0] op_a,
    input  logic [`EXU_XLEN-1:0] op_b,
    output exu_pkg::alu_op_e     alu_op,
    output logic [`EXU_XLEN-1:0] alu_a,
    output logic [`EXU_XLEN-1:0] alu_b
);

    logic is_reg;
    logic is_arith;

    assign is_reg   = (id.op_class == exu_pkg::op_alu_reg);
    assign is_arith = is_reg || (id.op_class == exu_pkg::op_alu_imm);

    // funct3 only matters for the arithmetic classes
    // everything else is an address or link add
    always_comb begin
        alu_op = exu_pkg::alu_add;
        if (is_arith) begin
            case (id.funct3)
                // addi has no subtract form
                3'd0: alu_op = (is_reg && id.alt) ? exu_pkg::alu_sub : exu_pkg::alu_add;
                3'd1: alu_op = exu_pkg::alu_sll;
                3'd2: alu_op = exu_pkg::alu_slt;
                3'd3: alu_op = exu_pkg::alu_sltu;
                3'd4: alu_op = exu_pkg::alu_xor;
                3'd5: alu_op = id.alt ? exu_pkg::alu_sra : exu_pkg::alu_srl;
                3'd6: alu_op = exu_pkg::alu_or;
                default: alu_op = exu_pkg::alu_and;
            endcase
        end
    end

    // operand a
    always_comb begin
        case (id.op_class)
            exu_pkg::op_lui:   alu_a = '0;
            exu_pkg::op_auipc: alu_a = id.pc;
            // link value comes from pc
            exu_pkg::op_jal,
            exu_pkg::op_jalr:  alu_a = id.pc;
            default:           alu_a = op_a;
        endcase
    end

    // operand b
    always_comb begin
        case (id.op_class)
            exu_pkg::op_jal,
            exu_pkg::op_jalr:    alu_b = `EXU_XLEN'(`EXU_INST_STEP);
            exu_pkg::op_lui,
            exu_pkg::op_auipc,
            exu_pkg::op_load,
            exu_pkg::op_store,
            exu_pkg::op_alu_imm: alu_b = id.imm;
            default:             alu_b = op_b;
        endcase
    end

endmodule

/* hdl/exu_alu.sv */
`timescale 1ns/1ps
`include "exu_params.svh"

module exu_alu (
    input  exu_pkg::alu_op_e     alu_op,
    input  logic [`EXU_XLEN-1:0] a,
    input  logic [`EXU_XLEN-1:0] b,
    output logic [`EXU_XLEN-1:0] result
);

    localparam int shamt_w = $clog2(`EXU_XLEN);

    logic [shamt_w-1:0] shamt;
    logic               lt_s;
    logic               lt_u;

    // rv64 shifts use the low six bits only
    assign shamt = b[shamt_w-1:0];
    assign lt_s  = $signed(a) < $signed(b);
    assign lt_u  = a < b;

    always_comb begin
        case (alu_op)
            exu_pkg::alu_add:  result = a + b;
            exu_pkg::alu_sub:  result = a - b;
            // set ops give 0 or 1
            exu_pkg::alu_slt:  result = {{(`EXU_XLEN-1){1'b0}}, lt_s};
            exu_pkg::alu_sltu: result = {{(`EXU_XLEN-1){1'b0}}, lt_u};
            exu_pkg::alu_and:  result = a & b;
            exu_pkg::alu_or:   result = a | b;
            exu_pkg::alu_xor:  result = a ^ b;
            exu_pkg::alu_sll:  result = a << shamt;
            exu_pkg::alu_srl:  result = a >> shamt;
            // sign fill from bit 63
            exu_pkg::alu_sra:  result = $unsigned($signed(a) >>> shamt);
            default:           result = '0;
        endcase
    end

endmodule

/* hdl/exu_branch.sv */
`timescale 1ns/1ps
`include "exu_params.svh"

module exu_branch (
    input  logic                 valid,
    input  logic                 fire,
    input  exu_pkg::id_ex_t      id,
    input  logic [`EXU_XLEN-1:0] op_a,
    input  logic [`EXU_XLEN-1:0] op_b,
    output exu_pkg::redirect_t   redirect
);

    logic is_jump;
    logic is_branch;
    logic cond;

    assign is_jump   = (id.op_class == exu_pkg::op_jal) || (id.op_class == exu_pkg::op_jalr);
    assign is_branch = (id.op_class == exu_pkg::op_branch);

    // funct3 2 and 3 are not branches
    always_comb begin
        case (id.funct3)
            3'd0:    cond = (op_a == op_b);
            3'd1:    cond = (op_a != op_b);
            3'd4:    cond = $signed(op_a) < $signed(op_b);
            3'd5:    cond = $signed(op_a) >= $signed(op_b);
            3'd6:    cond = op_a < op_b;
            3'd7:    cond = op_a >= op_b;
            default: cond = 1'b0;
        endcase
    end

    // jalr base is forwarded rs1, others pc relative
    // sum taken as is, bit 0 not cleared
    always_comb begin
        if (id.op_class == exu_pkg::op_jalr) begin
            redirect.target = op_a + id.imm;
        end else begin
            redirect.target = id.pc + id.imm;
        end
    end

    // only strobe in the cycle the instruction leaves
    assign redirect.taken = valid && fire && (is_jump || (is_branch && cond));

endmodule

/* hdl/exu_multiplier.sv */
`timescale 1ns/1ps
`include "exu_params.svh"

module exu_multiplier (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 start,
    input  logic                 clear,
    input  logic [`EXU_XLEN-1:0] multiplicand,
    input  logic [`EXU_XLEN-1:0] multiplier,
    output logic                 busy,
    output logic                 done,
    output logic [`EXU_XLEN-1:0] product
);

    localparam int cnt_w = $clog2(`EXU_MUL_CYCLES);

    logic [cnt_w-1:0]     count;
    logic [`EXU_XLEN-1:0] mcand;
    logic [`EXU_XLEN-1:0] mplier;
    logic                 idle;
    logic                 last;

    assign idle = !busy && !done;
    assign last = (count == cnt_w'(`EXU_MUL_CYCLES - 1));

    // control, clear wins over start and over iterating
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy  <= 1'b0;
            done  <= 1'b0;
            count <= '0;
        end else if (clear) begin
            busy  <= 1'b0;
            done  <= 1'b0;
            count <= '0;
        end else if (start && idle) begin
            busy  <= 1'b1;
            count <= '0;
        end else if (busy) begin
            count <= count + 1'b1;
            if (last) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    // data path, one multiplier bit per cycle
    // only the low half is kept, so mcand bits shifted out are dropped
    always_ff @(posedge clk) begin
        if (start && idle && !clear) begin
            mcand   <= multiplicand;
            mplier  <= multiplier;
            product <= '0;
        end else if (busy) begin
            if (mplier[0]) begin
                product <= product + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    // done and busy are exclusive phases
    property p_busy_done_excl;
        @(posedge clk) disable iff (!arst_n)
        !(busy && done);
    endproperty

    a_busy_done_excl : assert property (p_busy_done_excl)
        else $error("multiplier busy and done at once");

    // caller must not restart an operation in flight
    property p_no_start_busy;
        @(posedge clk) disable iff (!arst_n)
        start |-> !busy;
    endproperty

    a_no_start_busy : assert property (p_no_start_busy)
        else $error("multiplier start seen while busy");

endmodule

/* hdl/exu_top.sv */
`timescale 1ns/1ps
`include "exu_params.svh"

module exu_top (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                valid_id_ex,
    input  exu_pkg::id_ex_t     id_ex,
    output logic                ready_id_ex,
    input  exu_pkg::bypass_t    mem_bypass,
    input  exu_pkg::bypass_t    wb_bypass,
    input  logic                branch_flush,
    output logic                valid_ex_mem,
    input  logic                ready_ex_mem,
    output exu_pkg::ex_mem_t    ex_mem,
    output exu_pkg::redirect_t  redirect
);

    // held instruction
    logic                 valid;
    exu_pkg::id_ex_t      id;

    // stage controls
    logic                 load;
    logic                 fire;
    logic                 block;
    logic                 uses_rs2;
    logic                 is_mul;

    // forwarded operands
    logic [`EXU_XLEN-1:0] op_a;
    logic [`EXU_XLEN-1:0] op_b;

    // alu path
    exu_pkg::alu_op_e     alu_op;
    logic [`EXU_XLEN-1:0] alu_a;
    logic [`EXU_XLEN-1:0] alu_b;
    logic [`EXU_XLEN-1:0] alu_result;

    // multiplier
    logic                 mul_start;
    logic                 mul_clear;
    logic                 mul_busy;
    logic                 mul_done;
    logic [`EXU_XLEN-1:0] mul_product;

    assign is_mul   = (id.op_class == exu_pkg::op_mul);
    // classes that read rs2 as a register
    assign uses_rs2 = (id.op_class == exu_pkg::op_branch)
                   || (id.op_class == exu_pkg::op_store)
                   || (id.op_class == exu_pkg::op_alu_reg)
                   || is_mul;

    // unfinished multiply holds the stage
    assign block     = valid && is_mul && !mul_done;
    assign mul_start = valid && is_mul && !mul_busy && !mul_done;

    assign ready_id_ex = ready_ex_mem && !block;
    assign load        = ready_id_ex;
    assign fire        = valid && ready_ex_mem && !block;
    // next load or a flush ends the held multiply
    assign mul_clear   = load || branch_flush;

    assign valid_ex_mem = valid && !block;

    exu_stage_reg u_stage_reg (
        .clk      (clk),
        .arst_n   (arst_n),
        .load     (load),
        .flush    (branch_flush),
        .valid_in (valid_id_ex),
        .id_in    (id_ex),
        .valid    (valid),
        .id       (id)
    );

    exu_forward u_forward (
        .rs1        (id.rs1),
        .rs2        (id.rs2),
        .src_a      (id.src_a),
        .src_b      (id.src_b),
        .uses_rs2   (uses_rs2),
        .mem_bypass (mem_bypass),
        .wb_bypass  (wb_bypass),
        .op_a       (op_a),
        .op_b       (op_b)
    );

    exu_alu_ctrl u_alu_ctrl (
        .id     (id),
        .op_a   (op_a),
        .op_b   (op_b),
        .alu_op (alu_op),
        .alu_a  (alu_a),
        .alu_b  (alu_b)
    );

    exu_alu u_alu (
        .alu_op (alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_result)
    );

    exu_branch u_branch (
        .valid    (valid),
        .fire     (fire),
        .id       (id),
        .op_a     (op_a),
        .op_b     (op_b),
        .redirect (redirect)
    );

    exu_multiplier u_multiplier (
        .clk          (clk),
        .arst_n       (arst_n),
        .start        (mul_start),
        .clear        (mul_clear),
        .multiplicand (op_a),
        .multiplier   (op_b),
        .busy         (mul_busy),
        .done         (mul_done),
        .product      (mul_product)
    );

    // record for the memory stage
    always_comb begin
        ex_mem.pc         = id.pc;
        ex_mem.op_class   = id.op_class;
        ex_mem.funct3     = id.funct3;
        ex_mem.rd         = id.rd;
        ex_mem.result     = is_mul ? mul_product : alu_result;
        // forwarded rs2 is the store payload
        ex_mem.store_data = op_b;
    end

endmodule

/* testbench/tb_exu.sv */
`timescale 1ns/1ps
`include "exu_params.svh"

module tb_exu;

    localparam int xlen = `EXU_XLEN;
    // about 55 short instructions at 2 to 5 cycles plus 4 multiplies near 70 cycles
    // roughly 450 cycles in all, four times over and rounded up
    localparam int timeout_cycles = 2000;

    logic               clk;
    logic               arst_n;
    logic               valid_id_ex;
    exu_pkg::id_ex_t    id_ex;
    logic               ready_id_ex;
    exu_pkg::bypass_t   mem_bypass;
    exu_pkg::bypass_t   wb_bypass;
    logic               branch_flush;
    logic               valid_ex_mem;
    logic               ready_ex_mem;
    exu_pkg::ex_mem_t   ex_mem;
    exu_pkg::redirect_t redirect;

    integer seed;
    int     cycles;

    exu_top u_exu_top (
        .clk          (clk),
        .arst_n       (arst_n),
        .valid_id_ex  (valid_id_ex),
        .id_ex        (id_ex),
        .ready_id_ex  (ready_id_ex),
        .mem_bypass   (mem_bypass),
        .wb_bypass    (wb_bypass),
        .branch_flush (branch_flush),
        .valid_ex_mem (valid_ex_mem),
        .ready_ex_mem (ready_ex_mem),
        .ex_mem       (ex_mem),
        .redirect     (redirect)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // watchdog
    initial begin
        cycles = 0;
        while (cycles < timeout_cycles) begin
            @(posedge clk);
            cycles = cycles + 1;
        end
        $display("timeout reached after %0d cycles, the DUT stopped making progress", cycles);
        $display("Simulation failed");
        $fatal(1, "timeout");
    end

    task automatic report_failure(input string msg);
        $display("[FAIL] time %0t: %s", $time, msg);
        $display("Simulation failed");
        $fatal(1, "check failed");
    endtask

    task automatic check_ex_mem(input exu_pkg::ex_mem_t got, input exu_pkg::ex_mem_t exp,
                                input string what);
        if (got !== exp) begin
            report_failure($sformatf("%s: result %h store %h, expected result %h store %h",
                what, got.result, got.store_data, exp.result, exp.store_data));
        end
    endtask

    task automatic check_redirect(input exu_pkg::redirect_t got,
                                  input exu_pkg::redirect_t exp, input string what);
        if (got !== exp) begin
            report_failure($sformatf("%s: taken %b target %h, expected taken %b target %h",
                what, got.taken, got.target, exp.taken, exp.target));
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            report_failure($sformatf("%s: got %b, expected %b", what, got, exp));
        end
    endtask

    function automatic logic [xlen-1:0] rand64();
        rand64 = {$random(seed), $random(seed)};
    endfunction

    // reference model of the stage rules
    function automatic logic [xlen-1:0] fwd_value(input logic [`EXU_REG_W-1:0] rs,
        input logic [xlen-1:0] reg_val, input logic en,
        input exu_pkg::bypass_t mem, input exu_pkg::bypass_t wb);
        logic mem_hit;
        logic wb_hit;
        mem_hit = en && (rs != 0) && mem.wen && (mem.rd == rs);
        wb_hit = en && (rs != 0) && wb.wen && (wb.rd == rs);
        fwd_value = mem_hit ? mem.data : (wb_hit ? wb.data : reg_val);
    endfunction

    function automatic logic reads_rs2(input exu_pkg::op_class_e c);
        reads_rs2 = (c == exu_pkg::op_branch) || (c == exu_pkg::op_store)
                 || (c == exu_pkg::op_alu_reg) || (c == exu_pkg::op_mul);
    endfunction

    // rv64i integer ops by funct3 with sub only in register form
    function automatic logic [xlen-1:0] ref_arith(input logic [2:0] f3, input logic alt,
        input logic sub_ok, input logic [xlen-1:0] x, input logic [xlen-1:0] y);
        logic [5:0]             sh;
        logic signed [xlen-1:0] sx;
        logic signed [xlen-1:0] sy;
        sh = y[5:0];
        sx = x;
        sy = y;
        case (f3)
            3'd0: ref_arith = (sub_ok && alt) ? x - y : x + y;
            3'd1: ref_arith = x << sh;
            3'd2: ref_arith = (sx < sy) ? 64'd1 : 64'd0;
            3'd3: ref_arith = (x < y) ? 64'd1 : 64'd0;
            3'd4: ref_arith = x ^ y;
            3'd5: begin
                if (alt) ref_arith = sx >>> sh;
                else ref_arith = x >> sh;
            end
            3'd6: ref_arith = x | y;
            default: ref_arith = x & y;
        endcase
    endfunction

    function automatic logic ref_cond(input logic [2:0] f3, input logic [xlen-1:0] x,
                                      input logic [xlen-1:0] y);
        logic signed [xlen-1:0] sx;
        logic signed [xlen-1:0] sy;
        sx = x;
        sy = y;
        case (f3)
            3'd0: ref_cond = (x == y);
            3'd1: ref_cond = (x != y);
            3'd4: ref_cond = (sx < sy);
            3'd5: ref_cond = (sx >= sy);
            3'd6: ref_cond = (x < y);
            3'd7: ref_cond = (x >= y);
            default: ref_cond = 1'b0;
        endcase
    endfunction

    // a and b are the forwarded rs1 and rs2 values
    function automatic exu_pkg::ex_mem_t expect_ex_mem(input exu_pkg::id_ex_t i,
        input logic [xlen-1:0] a, input logic [xlen-1:0] b);
        logic [xlen-1:0]  res;
        exu_pkg::ex_mem_t e;
        case (i.op_class)
            exu_pkg::op_lui:     res = i.imm;
            exu_pkg::op_auipc:   res = i.pc + i.imm;
            exu_pkg::op_jal,
            exu_pkg::op_jalr:    res = i.pc + xlen'(`EXU_INST_STEP);
            exu_pkg::op_load,
            exu_pkg::op_store:   res = a + i.imm;
            exu_pkg::op_alu_imm: res = ref_arith(i.funct3, i.alt, 1'b0, a, i.imm);
            exu_pkg::op_alu_reg: res = ref_arith(i.funct3, i.alt, 1'b1, a, b);
            exu_pkg::op_mul:     res = a * b;
            // branch result is not checked
            default:             res = a + b;
        endcase
        e.pc = i.pc;
        e.op_class = i.op_class;
        e.funct3 = i.funct3;
        e.rd = i.rd;
        e.result = res;
        e.store_data = b;
        return e;
    endfunction

    function automatic exu_pkg::redirect_t expect_redirect(input exu_pkg::id_ex_t i,
        input logic [xlen-1:0] a, input logic [xlen-1:0] b, input logic fire);
        logic               jump;
        exu_pkg::redirect_t r;
        jump = (i.op_class == exu_pkg::op_jal) || (i.op_class == exu_pkg::op_jalr);
        if (i.op_class == exu_pkg::op_jalr) r.target = a + i.imm;
        else r.target = i.pc + i.imm;
        r.taken = fire && (jump
            || ((i.op_class == exu_pkg::op_branch) && ref_cond(i.funct3, a, b)));
        return r;
    endfunction

    function automatic exu_pkg::id_ex_t make_instr(input exu_pkg::op_class_e c,
        input logic [2:0] f3, input logic alt, input logic [`EXU_REG_W-1:0] rs1,
        input logic [`EXU_REG_W-1:0] rs2);
        exu_pkg::id_ex_t n;
        n.pc = rand64() & ~64'd3;
        n.op_class = c;
        n.funct3 = f3;
        n.alt = alt;
        n.rd = 5'($random(seed));
        n.rs1 = rs1;
        n.rs2 = rs2;
        n.src_a = rand64();
        n.src_b = rand64();
        n.imm = rand64();
        return n;
    endfunction

    // inputs change 1 ns after the edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // ends 1 ns into the cycle that holds the instruction
    task automatic accept(input exu_pkg::id_ex_t instr);
        next_cycle();
        valid_id_ex = 1'b1;
        id_ex = instr;
        while (!ready_id_ex) next_cycle();
        next_cycle();
        valid_id_ex = 1'b0;
        mem_bypass = '0;
        wb_bypass = '0;
    endtask

    task automatic run_and_check(input exu_pkg::id_ex_t instr, input exu_pkg::bypass_t mem,
                                 input exu_pkg::bypass_t wb, input string what);
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        accept(instr);
        mem_bypass = mem;
        wb_bypass = wb;
        #1;
        a = fwd_value(instr.rs1, instr.src_a, 1'b1, mem, wb);
        b = fwd_value(instr.rs2, instr.src_b, reads_rs2(instr.op_class), mem, wb);
        check_bit(valid_ex_mem, 1'b1, {what, " valid_ex_mem"});
        if (instr.op_class != exu_pkg::op_branch) begin
            check_ex_mem(ex_mem, expect_ex_mem(instr, a, b), what);
        end
        check_redirect(redirect, expect_redirect(instr, a, b, 1'b1), what);
    endtask

    task automatic test_alu_classes();
        logic [2:0]         f3_tab [10];
        logic               alt_tab [10];
        exu_pkg::op_class_e misc [6];
        exu_pkg::bypass_t   idle;
        idle = '0;
        f3_tab = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
        alt_tab = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
        misc = '{exu_pkg::op_lui, exu_pkg::op_auipc, exu_pkg::op_jal, exu_pkg::op_jalr,
                 exu_pkg::op_load, exu_pkg::op_store};
        for (int i = 0; i < 10; i++) begin
            run_and_check(make_instr(exu_pkg::op_alu_reg, f3_tab[i], alt_tab[i], 5'd3, 5'd4),
                          idle, idle, $sformatf("alu_reg op %0d", i));
            run_and_check(make_instr(exu_pkg::op_alu_imm, f3_tab[i], alt_tab[i], 5'd3, 5'd4),
                          idle, idle, $sformatf("alu_imm op %0d", i));
        end
        for (int i = 0; i < 6; i++) begin
            run_and_check(make_instr(misc[i], 3'd0, 1'b0, 5'd7, 5'd8), idle, idle,
                          $sformatf("class %s", misc[i].name()));
        end
    endtask

    task automatic test_forwarding();
        exu_pkg::bypass_t mem;
        exu_pkg::bypass_t wb;
        mem.wen = 1'b1;
        mem.rd = 5'd5;
        mem.data = rand64();
        wb.wen = 1'b1;
        wb.rd = 5'd5;
        wb.data = rand64();
        // memory stage is younger
        run_and_check(make_instr(exu_pkg::op_alu_reg, 3'd0, 1'b0, 5'd5, 5'd6), mem, wb,
                      "both bypasses on rs1");
        mem.rd = 5'd7;
        run_and_check(make_instr(exu_pkg::op_alu_reg, 3'd0, 1'b0, 5'd5, 5'd6), mem, wb,
                      "write-back bypass only");
        mem.rd = 5'd0;
        wb.rd = 5'd0;
        run_and_check(make_instr(exu_pkg::op_alu_reg, 3'd4, 1'b0, 5'd0, 5'd0), mem, wb,
                      "x0 bypass ignored");
        // rs2 field of an i-type is not a register
        mem.rd = 5'd9;
        run_and_check(make_instr(exu_pkg::op_alu_imm, 3'd0, 1'b0, 5'd2, 5'd9), mem, wb,
                      "alu_imm ignores rs2 bypass");
        wb.rd = 5'd12;
        run_and_check(make_instr(exu_pkg::op_store, 3'd3, 1'b0, 5'd2, 5'd12), mem, wb,
                      "store data from write-back");
    endtask

    task automatic test_branches();
        logic [xlen-1:0]  pair_a [3];
        logic [xlen-1:0]  pair_b [3];
        logic [2:0]       conds [6];
        exu_pkg::id_ex_t  instr;
        exu_pkg::bypass_t mem;
        exu_pkg::bypass_t idle;
        idle = '0;
        // equal, negative vs positive, positive vs negative
        pair_a[0] = rand64();
        pair_b[0] = pair_a[0];
        pair_a[1] = 64'hffff_ffff_ffff_fffb;
        pair_b[1] = 64'd3;
        pair_a[2] = 64'd3;
        pair_b[2] = 64'hffff_ffff_ffff_fffb;
        conds = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        for (int c = 0; c < 6; c++) begin
            for (int p = 0; p < 3; p++) begin
                instr = make_instr(exu_pkg::op_branch, conds[c], 1'b0, 5'd1, 5'd2);
                instr.src_a = pair_a[p];
                instr.src_b = pair_b[p];
                run_and_check(instr, idle, idle,
                              $sformatf("branch funct3 %0d pair %0d", conds[c], p));
            end
        end
        run_and_check(make_instr(exu_pkg::op_jal, 3'd0, 1'b0, 5'd1, 5'd2), idle, idle, "jal");
        mem.wen = 1'b1;
        mem.rd = 5'd8;
        mem.data = rand64();
        run_and_check(make_instr(exu_pkg::op_jalr, 3'd0, 1'b0, 5'd8, 5'd2), mem, idle,
                      "jalr with forwarded base");
    endtask

    // hold keeps ready_ex_mem low until the product has been seen
    task automatic test_multiply(input logic hold);
        exu_pkg::id_ex_t  instr;
        exu_pkg::ex_mem_t exp;
        int               waited;
        instr = make_instr(exu_pkg::op_mul, 3'd0, 1'b0, 5'd10, 5'd11);
        exp = expect_ex_mem(instr, instr.src_a, instr.src_b);
        accept(instr);
        if (hold) ready_ex_mem = 1'b0;
        #1;
        waited = 0;
        while (!valid_ex_mem) begin
            check_bit(ready_id_ex, 1'b0, "ready_id_ex during multiply");
            waited = waited + 1;
            if (waited > `EXU_MUL_CYCLES + 2) begin
                report_failure("multiply result did not appear within the expected latency");
            end
            next_cycle();
            #1;
        end
        check_ex_mem(ex_mem, exp, "multiply product");
        if (hold) begin
            repeat (3) begin
                next_cycle();
                #1;
                check_bit(valid_ex_mem, 1'b1, "held multiply valid");
                check_ex_mem(ex_mem, exp, "held multiply product");
            end
            next_cycle();
            ready_ex_mem = 1'b1;
        end
        next_cycle();
        #1;
        check_bit(valid_ex_mem, 1'b0, "multiply gone after next load");
    endtask

    task automatic test_backpressure();
        exu_pkg::id_ex_t  instr;
        exu_pkg::ex_mem_t snap;
        instr = make_instr(exu_pkg::op_branch, 3'd0, 1'b0, 5'd1, 5'd2);
        instr.src_b = instr.src_a;
        accept(instr);
        ready_ex_mem = 1'b0;
        // another word waits on the input while the slot is stalled
        id_ex = make_instr(exu_pkg::op_alu_reg, 3'd4, 1'b0, 5'd5, 5'd6);
        #1;
        snap = ex_mem;
        repeat (3) begin
            check_bit(valid_ex_mem, 1'b1, "valid_ex_mem under back-pressure");
            check_ex_mem(ex_mem, snap, "ex_mem under back-pressure");
            check_bit(ready_id_ex, 1'b0, "ready_id_ex under back-pressure");
            check_bit(redirect.taken, 1'b0, "redirect under back-pressure");
            next_cycle();
            #1;
        end
        next_cycle();
        ready_ex_mem = 1'b1;
        #1;
        check_redirect(redirect, expect_redirect(instr, instr.src_a, instr.src_b, 1'b1),
                       "pending branch after back-pressure");
    endtask

    task automatic test_flush();
        exu_pkg::bypass_t idle;
        idle = '0;
        // flush beats the instruction arriving behind it
        accept(make_instr(exu_pkg::op_alu_reg, 3'd0, 1'b0, 5'd3, 5'd4));
        valid_id_ex = 1'b1;
        id_ex = make_instr(exu_pkg::op_alu_imm, 3'd6, 1'b0, 5'd3, 5'd4);
        branch_flush = 1'b1;
        #1;
        check_bit(valid_ex_mem, 1'b1, "held instruction before flush");
        next_cycle();
        valid_id_ex = 1'b0;
        branch_flush = 1'b0;
        #1;
        check_bit(valid_ex_mem, 1'b0, "valid_ex_mem after flush");
        // abandon a multiply midway
        accept(make_instr(exu_pkg::op_mul, 3'd0, 1'b0, 5'd10, 5'd11));
        repeat (5) next_cycle();
        branch_flush = 1'b1;
        next_cycle();
        branch_flush = 1'b0;
        #1;
        check_bit(valid_ex_mem, 1'b0, "valid_ex_mem after flushed multiply");
        check_bit(ready_id_ex, 1'b1, "ready_id_ex after flushed multiply");
        test_multiply(1'b0);
        run_and_check(make_instr(exu_pkg::op_alu_reg, 3'd0, 1'b1, 5'd3, 5'd4), idle, idle,
                      "alu after flush");
    endtask

    initial begin
        seed = 17736;
        arst_n = 1'b0;
        valid_id_ex = 1'b0;
        id_ex = '0;
        mem_bypass = '0;
        wb_bypass = '0;
        branch_flush = 1'b0;
        ready_ex_mem = 1'b1;
        repeat (8) @(posedge clk);
        #1;
        arst_n = 1'b1;
        #1;
        check_bit(valid_ex_mem, 1'b0, "valid_ex_mem after reset");
        check_bit(redirect.taken, 1'b0, "redirect after reset");
        test_alu_classes();
        test_forwarding();
        test_branches();
        test_multiply(1'b0);
        test_multiply(1'b1);
        test_backpressure();
        test_flush();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

/* list.f */
+incdir+include
hdl/exu_pkg.sv
hdl/exu_stage_reg.sv
hdl/exu_forward.sv
hdl/exu_alu_ctrl.sv
hdl/exu_alu.sv
hdl/exu_branch.sv
hdl/exu_multiplier.sv
hdl/exu_top.sv
testbench/tb_exu.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module tb_exu -o tb_exu

out=$(./obj_dir/tb_exu 2>&1) || true
echo "$out"

if echo "$out" | grep -q "Simulation completed successfully"; then
    exit 0
else
    exit 1
fi
